// File: logic/axi_macros.svh
// widths and table depth shared by the AXI ID remapper
// upstream and downstream ID widths, payload widths, slot count

`ifndef AXI_MACROS_SVH
`define AXI_MACROS_SVH

// wide ID on the manager side, narrow ID on the subordinate side
`define AXI_ID_W      4
`define AXI_NID_W     2

// one slot per narrow ID value
`define AXI_MAX_TXNS  4

// payload widths
`define AXI_ADDR_W    32
`define AXI_DATA_W    32
`define AXI_STRB_W    (`AXI_DATA_W / 8)
`define AXI_USER_W    1

`endif

// File: logic/axi_pkg.sv
// AXI4 channel payload structs for the wide and narrow ID ports
// burst and response encodings, request/response bundles

`include "axi_macros.svh"

package axi_pkg;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    // upstream side, wide IDs
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [7:0]             len;
        logic [2:0]             size;
        axi_burst_e             burst;
        logic                   lock;
        logic [3:0]             cache;
        logic [2:0]             prot;
        logic [3:0]             qos;
        logic [3:0]             region;
        logic [5:0]             atop;
        logic [`AXI_USER_W-1:0] user;
    } aw_chan_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [7:0]             len;
        logic [2:0]             size;
        axi_burst_e             burst;
        logic                   lock;
        logic [3:0]             cache;
        logic [2:0]             prot;
        logic [3:0]             qos;
        logic [3:0]             region;
        logic [`AXI_USER_W-1:0] user;
    } ar_chan_t;

    // W has no ID, same on both ports
    typedef struct packed {
        logic [`AXI_DATA_W-1:0] data;
        logic [`AXI_STRB_W-1:0] strb;
        logic                   last;
        logic [`AXI_USER_W-1:0] user;
    } w_chan_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        axi_resp_e              resp;
        logic [`AXI_USER_W-1:0] user;
    } b_chan_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] data;
        axi_resp_e              resp;
        logic                   last;
        logic [`AXI_USER_W-1:0] user;
    } r_chan_t;

    // downstream side, narrow IDs
    typedef struct packed {
        logic [`AXI_NID_W-1:0]  id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [7:0]             len;
        logic [2:0]             size;
        axi_burst_e             burst;
        logic                   lock;
        logic [3:0]             cache;
        logic [2:0]             prot;
        logic [3:0]             qos;
        logic [3:0]             region;
        logic [5:0]             atop;
        logic [`AXI_USER_W-1:0] user;
    } aw_nchan_t;

    typedef struct packed {
        logic [`AXI_NID_W-1:0]  id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [7:0]             len;
        logic [2:0]             size;
        axi_burst_e             burst;
        logic                   lock;
        logic [3:0]             cache;
        logic [2:0]             prot;
        logic [3:0]             qos;
        logic [3:0]             region;
        logic [`AXI_USER_W-1:0] user;
    } ar_nchan_t;

    typedef struct packed {
        logic [`AXI_NID_W-1:0]  id;
        axi_resp_e              resp;
        logic [`AXI_USER_W-1:0] user;
    } b_nchan_t;

    typedef struct packed {
        logic [`AXI_NID_W-1:0]  id;
        logic [`AXI_DATA_W-1:0] data;
        axi_resp_e              resp;
        logic                   last;
        logic [`AXI_USER_W-1:0] user;
    } r_nchan_t;

    // bundles, manager drives req, subordinate drives resp
    typedef struct packed {
        aw_chan_t aw;
        logic     aw_valid;
        w_chan_t  w;
        logic     w_valid;
        logic     b_ready;
        ar_chan_t ar;
        logic     ar_valid;
        logic     r_ready;
    } req_t;

    typedef struct packed {
        logic    aw_ready;
        logic    ar_ready;
        logic    w_ready;
        logic    b_valid;
        b_chan_t b;
        logic    r_valid;
        r_chan_t r;
    } resp_t;

    typedef struct packed {
        aw_nchan_t aw;
        logic      aw_valid;
        w_chan_t   w;
        logic      w_valid;
        logic      b_ready;
        ar_nchan_t ar;
        logic      ar_valid;
        logic      r_ready;
    } nreq_t;

    typedef struct packed {
        logic     aw_ready;
        logic     ar_ready;
        logic     w_ready;
        logic     b_valid;
        b_nchan_t b;
        logic     r_valid;
        r_nchan_t r;
    } nresp_t;

endpackage

// File: logic/remap_pkg.sv
// remap table types
// slot state and the per-slot entry holding the upstream ID

`include "axi_macros.svh"

package remap_pkg;

    // a slot is BUSY from its request handshake until its final response
    typedef enum logic {
        FREE = 1'b0,
        BUSY = 1'b1
    } slot_state_e;

    // upstream ID parked while the narrow ID is in flight
    typedef struct packed {
        slot_state_e          state;
        logic [`AXI_ID_W-1:0] id;
    } slot_t;

endpackage

// File: logic/axi_chan_reg.sv
// one-entry valid/ready register for a single AXI channel
// cuts the valid and data paths, one cycle of latency

`timescale 1ns/1ps

module axi_chan_reg #(
    parameter type chan_t = logic
) (
    input  logic  clk_i,
    input  logic  reset,
    input  logic  in_valid,
    output logic  in_ready,
    input  chan_t in_data,
    output logic  out_valid,
    input  logic  out_ready,
    output chan_t out_data
);

    logic  full_q;
    logic  load;
    chan_t data_q;

    // room when empty or when the held beat leaves this cycle
    assign in_ready  = ~full_q | out_ready;
    assign load      = in_valid & in_ready;

    assign out_valid = full_q;
    assign out_data  = data_q;

    always_ff @(posedge clk_i) begin
        if (reset) begin
            full_q <= 1'b0;
        end else if (in_ready) begin
            // either refilled by a new beat or drained
            full_q <= in_valid;
        end
    end

    // payload only moves on a handshake, held otherwise
    always_ff @(posedge clk_i) begin
        if (load) begin
            data_q <= in_data;
        end
    end

endmodule

// File: logic/axi_id_table.sv
// narrow ID slot table for one direction
// allocates the lowest free slot, looks up and frees by narrow ID

`timescale 1ns/1ps

`include "axi_macros.svh"

module axi_id_table (
    input  logic                  clk_i,
    input  logic                  reset,
    // allocation commits when req and gnt are both high
    input  logic                  alloc_req,
    output logic                  alloc_gnt,
    input  logic [`AXI_ID_W-1:0]  alloc_id,
    output logic [`AXI_NID_W-1:0] alloc_nid,
    // combinational response side lookup
    input  logic [`AXI_NID_W-1:0] lookup_nid,
    output logic [`AXI_ID_W-1:0]  lookup_id,
    // release on the final response
    input  logic                  free_valid,
    input  logic [`AXI_NID_W-1:0] free_nid
);

    import remap_pkg::*;

    slot_t slots [`AXI_MAX_TXNS];
    logic  any_free;
    logic  alloc_do;

    // priority search where the lowest index wins
    always_comb begin
        any_free  = 1'b0;
        alloc_nid = '0;
        for (int i = `AXI_MAX_TXNS - 1; i >= 0; i--) begin
            if (slots[i].state == FREE) begin
                any_free  = 1'b1;
                alloc_nid = `AXI_NID_W'(i);
            end
        end
    end

    // grant does not wait for the request so upstream ready can use it directly
    assign alloc_gnt = any_free;
    assign alloc_do  = alloc_req & any_free;

    assign lookup_id = slots[lookup_nid].id;

    // the freed slot is always BUSY and the allocated one FREE,
    // so both can happen in one cycle without a conflict
    always_ff @(posedge clk_i) begin
        if (reset) begin
            for (int i = 0; i < `AXI_MAX_TXNS; i++) begin
                slots[i].state <= FREE;
            end
        end else begin
            if (free_valid) begin
                slots[free_nid].state <= FREE;
            end
            if (alloc_do) begin
                slots[alloc_nid].state <= BUSY;
                // stored upstream ID only meaningful while BUSY
                slots[alloc_nid].id    <= alloc_id;
            end
        end
    end

endmodule

// File: logic/axi_id_remap.sv
// AXI4 ID remapper top level
// wide upstream IDs to table slot indices downstream and back,
// every channel registered once in each direction

`timescale 1ns/1ps

`include "axi_macros.svh"

module axi_id_remap (
    input  logic            clk_i,
    input  logic            reset,
    input  axi_pkg::req_t   slv_req,
    output axi_pkg::resp_t  slv_resp,
    output axi_pkg::nreq_t  mst_req,
    input  axi_pkg::nresp_t mst_resp
);

    import axi_pkg::*;

    // responses keep their narrow ID next to the payload so the slot
    // can be freed when the beat leaves on the upstream side
    typedef struct packed {
        logic [`AXI_NID_W-1:0] nid;
        b_chan_t               b;
    } b_tag_t;

    typedef struct packed {
        logic [`AXI_NID_W-1:0] nid;
        r_chan_t               r;
    } r_tag_t;

    // write direction
    logic                  aw_gnt;
    logic                  aw_in_ready;
    logic [`AXI_NID_W-1:0] aw_nid;
    aw_nchan_t             aw_n;
    logic [`AXI_ID_W-1:0]  b_id;
    b_tag_t                b_in;
    b_tag_t                b_out;
    logic                  b_out_valid;

    // read direction
    logic                  ar_gnt;
    logic                  ar_in_ready;
    logic [`AXI_NID_W-1:0] ar_nid;
    ar_nchan_t             ar_n;
    logic [`AXI_ID_W-1:0]  r_id;
    r_tag_t                r_in;
    r_tag_t                r_out;
    logic                  r_out_valid;

    // requests take the granted slot index as their ID
    always_comb begin
        aw_n        = '0;
        aw_n.id     = aw_nid;
        aw_n.addr   = slv_req.aw.addr;
        aw_n.len    = slv_req.aw.len;
        aw_n.size   = slv_req.aw.size;
        aw_n.burst  = slv_req.aw.burst;
        aw_n.lock   = slv_req.aw.lock;
        aw_n.cache  = slv_req.aw.cache;
        aw_n.prot   = slv_req.aw.prot;
        aw_n.qos    = slv_req.aw.qos;
        aw_n.region = slv_req.aw.region;
        aw_n.atop   = slv_req.aw.atop;
        aw_n.user   = slv_req.aw.user;
    end

    always_comb begin
        ar_n        = '0;
        ar_n.id     = ar_nid;
        ar_n.addr   = slv_req.ar.addr;
        ar_n.len    = slv_req.ar.len;
        ar_n.size   = slv_req.ar.size;
        ar_n.burst  = slv_req.ar.burst;
        ar_n.lock   = slv_req.ar.lock;
        ar_n.cache  = slv_req.ar.cache;
        ar_n.prot   = slv_req.ar.prot;
        ar_n.qos    = slv_req.ar.qos;
        ar_n.region = slv_req.ar.region;
        ar_n.user   = slv_req.ar.user;
    end

    // responses get the upstream ID back from the table
    always_comb begin
        b_in        = '0;
        b_in.nid    = mst_resp.b.id;
        b_in.b.id   = b_id;
        b_in.b.resp = mst_resp.b.resp;
        b_in.b.user = mst_resp.b.user;
    end

    always_comb begin
        r_in        = '0;
        r_in.nid    = mst_resp.r.id;
        r_in.r.id   = r_id;
        r_in.r.data = mst_resp.r.data;
        r_in.r.resp = mst_resp.r.resp;
        r_in.r.last = mst_resp.r.last;
        r_in.r.user = mst_resp.r.user;
    end

    // no free slot stalls the address channel upstream
    assign slv_resp.aw_ready = aw_in_ready & aw_gnt;
    assign slv_resp.ar_ready = ar_in_ready & ar_gnt;
    assign slv_resp.b_valid  = b_out_valid;
    assign slv_resp.b        = b_out.b;
    assign slv_resp.r_valid  = r_out_valid;
    assign slv_resp.r        = r_out.r;

    axi_id_table wr_table (
        .clk_i      (clk_i),
        .reset      (reset),
        .alloc_req  (slv_req.aw_valid & aw_in_ready),
        .alloc_gnt  (aw_gnt),
        .alloc_id   (slv_req.aw.id),
        .alloc_nid  (aw_nid),
        .lookup_nid (mst_resp.b.id),
        .lookup_id  (b_id),
        .free_valid (b_out_valid & slv_req.b_ready),
        .free_nid   (b_out.nid)
    );

    // a read slot lives until its last R beat is taken upstream
    axi_id_table rd_table (
        .clk_i      (clk_i),
        .reset      (reset),
        .alloc_req  (slv_req.ar_valid & ar_in_ready),
        .alloc_gnt  (ar_gnt),
        .alloc_id   (slv_req.ar.id),
        .alloc_nid  (ar_nid),
        .lookup_nid (mst_resp.r.id),
        .lookup_id  (r_id),
        .free_valid (r_out_valid & slv_req.r_ready & r_out.r.last),
        .free_nid   (r_out.nid)
    );

    axi_chan_reg #(.chan_t(aw_nchan_t)) aw_reg (
        .clk_i     (clk_i),
        .reset     (reset),
        .in_valid  (slv_req.aw_valid & aw_gnt),
        .in_ready  (aw_in_ready),
        .in_data   (aw_n),
        .out_valid (mst_req.aw_valid),
        .out_ready (mst_resp.aw_ready),
        .out_data  (mst_req.aw)
    );

    axi_chan_reg #(.chan_t(w_chan_t)) w_reg (
        .clk_i     (clk_i),
        .reset     (reset),
        .in_valid  (slv_req.w_valid),
        .in_ready  (slv_resp.w_ready),
        .in_data   (slv_req.w),
        .out_valid (mst_req.w_valid),
        .out_ready (mst_resp.w_ready),
        .out_data  (mst_req.w)
    );

    axi_chan_reg #(.chan_t(ar_nchan_t)) ar_reg (
        .clk_i     (clk_i),
        .reset     (reset),
        .in_valid  (slv_req.ar_valid & ar_gnt),
        .in_ready  (ar_in_ready),
        .in_data   (ar_n),
        .out_valid (mst_req.ar_valid),
        .out_ready (mst_resp.ar_ready),
        .out_data  (mst_req.ar)
    );

    axi_chan_reg #(.chan_t(b_tag_t)) b_reg (
        .clk_i     (clk_i),
        .reset     (reset),
        .in_valid  (mst_resp.b_valid),
        .in_ready  (mst_req.b_ready),
        .in_data   (b_in),
        .out_valid (b_out_valid),
        .out_ready (slv_req.b_ready),
        .out_data  (b_out)
    );

    axi_chan_reg #(.chan_t(r_tag_t)) r_reg (
        .clk_i     (clk_i),
        .reset     (reset),
        .in_valid  (mst_resp.r_valid),
        .in_ready  (mst_req.r_ready),
        .in_data   (r_in),
        .out_valid (r_out_valid),
        .out_ready (slv_req.r_ready),
        .out_data  (r_out)
    );

endmodule

// File: sim/axi_channel_compare.sv
// scoreboard for the AXI ID remapper, one queue per channel
// in-order payload equality between ports A and B, IDs ignored

`timescale 1ns/1ps

`include "axi_macros.svh"

module axi_channel_compare (
    input  logic            clk_i,
    input  logic            reset,
    input  logic            check_end,
    input  axi_pkg::req_t   slv_req,
    input  axi_pkg::resp_t  slv_resp,
    input  axi_pkg::nreq_t  mst_req,
    input  axi_pkg::nresp_t mst_resp,
    output int              errors
);

    import axi_pkg::*;

    // id sits in the top bits, everything below it is compared
    localparam int AW_W = $bits(aw_chan_t) - `AXI_ID_W;
    localparam int AR_W = $bits(ar_chan_t) - `AXI_ID_W;
    localparam int W_W  = $bits(w_chan_t);
    localparam int B_W  = $bits(b_chan_t) - `AXI_ID_W;
    localparam int R_W  = $bits(r_chan_t) - `AXI_ID_W;

    logic [AW_W-1:0] aw_q [$];
    logic [AR_W-1:0] ar_q [$];
    logic [W_W-1:0]  w_q [$];
    logic [B_W-1:0]  b_q [$];
    logic [R_W-1:0]  r_q [$];
    int              err_cnt = 0;

    assign errors = err_cnt;

    task automatic match_beat(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
        assert (got == exp) else begin
            err_cnt++;
            $display("Error %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic unexpected_beat(input string name);
        err_cnt++;
        $display("Error %0t: %s delivered a beat that was never accepted", $time, name);
    endtask

    task automatic leftover_beats(input string name, input int n);
        assert (n == 0) else begin
            err_cnt++;
            $display("Error %0t: %s still holds %0d accepted beats not delivered",
                     $time, name, n);
        end
    endtask

    always @(posedge clk_i) begin
        if (!reset) begin
            // requests enter on A
            if (slv_req.aw_valid && slv_resp.aw_ready) aw_q.push_back(slv_req.aw[AW_W-1:0]);
            if (slv_req.ar_valid && slv_resp.ar_ready) ar_q.push_back(slv_req.ar[AR_W-1:0]);
            if (slv_req.w_valid && slv_resp.w_ready) w_q.push_back(slv_req.w);
            // responses enter on B
            if (mst_resp.b_valid && mst_req.b_ready) b_q.push_back(mst_resp.b[B_W-1:0]);
            if (mst_resp.r_valid && mst_req.r_ready) r_q.push_back(mst_resp.r[R_W-1:0]);

            if (mst_req.aw_valid && mst_resp.aw_ready) begin
                if (aw_q.size() == 0) unexpected_beat("mst_req.aw");
                else match_beat("mst_req.aw", 128'(mst_req.aw[AW_W-1:0]), 128'(aw_q.pop_front()));
            end
            if (mst_req.ar_valid && mst_resp.ar_ready) begin
                if (ar_q.size() == 0) unexpected_beat("mst_req.ar");
                else match_beat("mst_req.ar", 128'(mst_req.ar[AR_W-1:0]), 128'(ar_q.pop_front()));
            end
            if (mst_req.w_valid && mst_resp.w_ready) begin
                if (w_q.size() == 0) unexpected_beat("mst_req.w");
                else match_beat("mst_req.w", 128'(mst_req.w), 128'(w_q.pop_front()));
            end
            if (slv_resp.b_valid && slv_req.b_ready) begin
                if (b_q.size() == 0) unexpected_beat("slv_resp.b");
                else match_beat("slv_resp.b", 128'(slv_resp.b[B_W-1:0]), 128'(b_q.pop_front()));
            end
            if (slv_resp.r_valid && slv_req.r_ready) begin
                if (r_q.size() == 0) unexpected_beat("slv_resp.r");
                else match_beat("slv_resp.r", 128'(slv_resp.r[R_W-1:0]), 128'(r_q.pop_front()));
            end

            // accepted and delivered counts agree once traffic stops
            if (check_end) begin
                leftover_beats("aw channel", aw_q.size());
                leftover_beats("ar channel", ar_q.size());
                leftover_beats("w channel", w_q.size());
                leftover_beats("b channel", b_q.size());
                leftover_beats("r channel", r_q.size());
            end
        end
    end

endmodule

// File: sim/tb_axi_id_remap.sv
// testbench for the AXI ID remapper
// random manager, in-order subordinate, ID restoration and slot limit checks

`timescale 1ns/1ps

`include "axi_macros.svh"

module tb_axi_id_remap;

    import axi_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_PHASE1   = 6;
    localparam int N_WR       = 24;
    localparam int N_RD       = 24;
    localparam int N_TXNS     = N_PHASE1 + N_WR + N_RD;
    // generous cycle budget for one burst under random back-pressure
    localparam int TXN_BOUND  = 60;

    logic     clk_i = 1'b0;
    logic     reset;
    logic     hold_b;
    logic     check_end;
    req_t     slv_req;
    resp_t    slv_resp;
    nreq_t    mst_req;
    nresp_t   mst_resp;
    int       sb_errors;
    int       errors = 0;

    // manager side drive
    aw_chan_t aw_d;
    ar_chan_t ar_d;
    w_chan_t  w_d;
    logic     aw_valid_d, ar_valid_d, w_valid_d, b_ready_d, r_ready_d;

    // subordinate side drive
    b_nchan_t b_s;
    r_nchan_t r_s;
    logic     b_valid_s, r_valid_s, aw_ready_s, ar_ready_s, w_ready_s;

    // subordinate bookkeeping
    logic [`AXI_NID_W-1:0] sub_awq [$];
    ar_nchan_t             sub_arq [$];
    ar_nchan_t             cur_ar;
    logic [7:0]            beat;
    int                    wlast_cnt = 0;

    // ID tracking from narrow back to upstream
    logic [`AXI_ID_W-1:0]     wid_q [$], rid_q [$], bexp_q [$], rexp_q [$];
    logic [`AXI_ID_W-1:0]     wmap [`AXI_MAX_TXNS];
    logic [`AXI_ID_W-1:0]     rmap [`AXI_MAX_TXNS];
    logic [`AXI_MAX_TXNS-1:0] wbusy = '0;
    logic [`AXI_MAX_TXNS-1:0] rbusy = '0;
    int                       aw_b_cnt = 0;
    int                       b_a_cnt = 0;
    int                       rlast_a_cnt = 0;
    int                       cyc = 0;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always_comb begin
        slv_req          = '0;
        slv_req.aw       = aw_d;
        slv_req.aw_valid = aw_valid_d;
        slv_req.w        = w_d;
        slv_req.w_valid  = w_valid_d;
        slv_req.b_ready  = b_ready_d;
        slv_req.ar       = ar_d;
        slv_req.ar_valid = ar_valid_d;
        slv_req.r_ready  = r_ready_d;
    end

    always_comb begin
        mst_resp          = '0;
        mst_resp.aw_ready = aw_ready_s;
        mst_resp.ar_ready = ar_ready_s;
        mst_resp.w_ready  = w_ready_s;
        mst_resp.b_valid  = b_valid_s;
        mst_resp.b        = b_s;
        mst_resp.r_valid  = r_valid_s;
        mst_resp.r        = r_s;
    end

    axi_id_remap dut0 (
        .clk_i    (clk_i),
        .reset    (reset),
        .slv_req  (slv_req),
        .slv_resp (slv_resp),
        .mst_req  (mst_req),
        .mst_resp (mst_resp)
    );

    axi_channel_compare sb0 (
        .clk_i     (clk_i),
        .reset     (reset),
        .check_end (check_end),
        .slv_req   (slv_req),
        .slv_resp  (slv_resp),
        .mst_req   (mst_req),
        .mst_resp  (mst_resp),
        .errors    (sb_errors)
    );

    task automatic check_val(input string name, input int got, input int exp);
        assert (got == exp) else begin
            errors++;
            $display("Error %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic idle_gap();
        int n;
        n = $urandom % 3;
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // one write burst with AW first and then its W beats
    task automatic write_txn();
        int         len;
        logic [31:0] rnd;
        len  = $urandom % 4;
        rnd  = $urandom;
        aw_d        = '0;
        aw_d.id     = rnd[`AXI_ID_W-1:0];
        aw_d.addr   = $urandom & 32'hffff_fffc;
        aw_d.len    = 8'(len);
        aw_d.size   = 3'd2;
        aw_d.burst  = BURST_INCR;
        aw_d.lock   = rnd[15];
        aw_d.cache  = rnd[11:8];
        aw_d.prot   = rnd[14:12];
        aw_d.qos    = rnd[19:16];
        aw_d.region = rnd[7:4];
        aw_d.atop   = rnd[25:20];
        aw_d.user   = rnd[28 +: `AXI_USER_W];
        aw_valid_d  = 1'b1;
        do @(posedge clk_i); while (!slv_resp.aw_ready);
        #1 aw_valid_d = 1'b0;
        for (int i = 0; i <= len; i++) begin
            rnd        = $urandom;
            w_d.data   = $urandom;
            w_d.strb   = rnd[`AXI_STRB_W-1:0];
            w_d.last   = (i == len);
            w_d.user   = rnd[8 +: `AXI_USER_W];
            w_valid_d  = 1'b1;
            do @(posedge clk_i); while (!slv_resp.w_ready);
            #1;
        end
        w_valid_d = 1'b0;
        idle_gap();
    endtask

    task automatic read_txn();
        logic [31:0] rnd;
        rnd        = $urandom;
        ar_d        = '0;
        ar_d.id     = rnd[`AXI_ID_W-1:0];
        ar_d.addr   = $urandom & 32'hffff_fffc;
        ar_d.len    = 8'(rnd[5:4]);
        ar_d.size   = 3'd2;
        ar_d.burst  = BURST_INCR;
        ar_d.lock   = rnd[15];
        ar_d.cache  = rnd[11:8];
        ar_d.prot   = rnd[14:12];
        ar_d.qos    = rnd[19:16];
        ar_d.region = rnd[23:20];
        ar_d.user   = rnd[28 +: `AXI_USER_W];
        ar_valid_d  = 1'b1;
        do @(posedge clk_i); while (!slv_resp.ar_ready);
        #1 ar_valid_d = 1'b0;
        idle_gap();
    endtask

    // in-order subordinate whose read data follows the address
    always @(posedge clk_i) begin : subordinate
        logic b_hs;
        logic r_hs;
        b_hs = b_valid_s && mst_req.b_ready;
        r_hs = r_valid_s && mst_req.r_ready;
        if (!reset) begin
            if (mst_req.aw_valid && aw_ready_s) sub_awq.push_back(mst_req.aw.id);
            if (mst_req.w_valid && w_ready_s && mst_req.w.last) wlast_cnt++;
            if (mst_req.ar_valid && ar_ready_s) sub_arq.push_back(mst_req.ar);
        end
        #1;
        aw_ready_s = ($urandom % 4) != 0;
        ar_ready_s = ($urandom % 4) != 0;
        w_ready_s  = ($urandom % 4) != 0;
        if (reset) begin
            b_valid_s = 1'b0;
            r_valid_s = 1'b0;
        end else begin
            if (b_hs) b_valid_s = 1'b0;
            if (r_hs) begin
                if (r_s.last) begin
                    r_valid_s = 1'b0;
                end else begin
                    beat     = beat + 8'd1;
                    r_s.data = cur_ar.addr + {22'd0, beat, 2'b00};
                    r_s.last = (beat == cur_ar.len);
                end
            end
            if (!b_valid_s && !hold_b && sub_awq.size() > 0 && wlast_cnt > 0
                    && ($urandom % 2) == 1) begin
                wlast_cnt--;
                b_s.id    = sub_awq.pop_front();
                b_s.resp  = (($urandom % 4) == 0) ? RESP_SLVERR : RESP_OKAY;
                b_s.user  = `AXI_USER_W'($urandom % 2);
                b_valid_s = 1'b1;
            end
            if (!r_valid_s && sub_arq.size() > 0 && ($urandom % 2) == 1) begin
                cur_ar    = sub_arq.pop_front();
                beat      = 8'd0;
                r_s.id    = cur_ar.id;
                r_s.data  = cur_ar.addr;
                r_s.resp  = (($urandom % 4) == 0) ? RESP_EXOKAY : RESP_OKAY;
                r_s.last  = (cur_ar.len == 8'd0);
                r_s.user  = cur_ar.user;
                r_valid_s = 1'b1;
            end
        end
    end

    // random response ready on port A
    always @(posedge clk_i) begin
        #1;
        b_ready_d = ($urandom % 4) != 0;
        r_ready_d = ($urandom % 4) != 0;
    end

    // ID restoration, narrow ID uniqueness, reset values
    always @(posedge clk_i) begin
        cyc++;
        // up to the first edge after reset is released
        if (cyc >= 2 && cyc <= 17) begin
            assert (!slv_resp.b_valid && !slv_resp.r_valid && !mst_req.aw_valid
                    && !mst_req.w_valid && !mst_req.ar_valid) else begin
                errors++;
                $display("Error %0t: a valid is high during or right after reset", $time);
            end
        end
        if (!reset) begin
            if (slv_req.aw_valid && slv_resp.aw_ready) wid_q.push_back(slv_req.aw.id);
            if (slv_req.ar_valid && slv_resp.ar_ready) rid_q.push_back(slv_req.ar.id);
            if (mst_req.aw_valid && mst_resp.aw_ready) begin
                aw_b_cnt++;
                assert (!wbusy[mst_req.aw.id]) else begin
                    errors++;
                    $display("Error %0t: narrow write ID %0d reused while outstanding",
                             $time, mst_req.aw.id);
                end
                wbusy[mst_req.aw.id] = 1'b1;
                if (wid_q.size() > 0) wmap[mst_req.aw.id] = wid_q.pop_front();
            end
            if (mst_req.ar_valid && mst_resp.ar_ready) begin
                assert (!rbusy[mst_req.ar.id]) else begin
                    errors++;
                    $display("Error %0t: narrow read ID %0d reused while outstanding",
                             $time, mst_req.ar.id);
                end
                rbusy[mst_req.ar.id] = 1'b1;
                if (rid_q.size() > 0) rmap[mst_req.ar.id] = rid_q.pop_front();
            end
            if (mst_resp.b_valid && mst_req.b_ready) begin
                bexp_q.push_back(wmap[mst_resp.b.id]);
                wbusy[mst_resp.b.id] = 1'b0;
            end
            if (mst_resp.r_valid && mst_req.r_ready && mst_resp.r.last) begin
                rexp_q.push_back(rmap[mst_resp.r.id]);
                rbusy[mst_resp.r.id] = 1'b0;
            end
            if (slv_resp.b_valid && slv_req.b_ready) begin
                b_a_cnt++;
                if (bexp_q.size() > 0) begin
                    check_val("slv_resp.b.id", slv_resp.b.id, bexp_q.pop_front());
                end
            end
            if (slv_resp.r_valid && slv_req.r_ready && slv_resp.r.last) begin
                rlast_a_cnt++;
                if (rexp_q.size() > 0) begin
                    check_val("slv_resp.r.id", slv_resp.r.id, rexp_q.pop_front());
                end
            end
        end
    end

    initial begin
        #(N_TXNS * TXN_BOUND * CLK_PERIOD * 1ns);
        $display("watchdog expired before all transactions completed");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(32'h4a89_1a40));
        reset      = 1'b1;
        hold_b     = 1'b1;
        check_end  = 1'b0;
        aw_d       = '0;
        ar_d       = '0;
        w_d        = '0;
        aw_valid_d = 1'b0;
        ar_valid_d = 1'b0;
        w_valid_d  = 1'b0;
        b_ready_d  = 1'b0;
        r_ready_d  = 1'b0;
        b_s        = '0;
        r_s        = '0;
        b_valid_s  = 1'b0;
        r_valid_s  = 1'b0;
        aw_ready_s = 1'b0;
        ar_ready_s = 1'b0;
        w_ready_s  = 1'b0;
        repeat (16) @(posedge clk_i);
        #1 reset = 1'b0;

        // with B held back only as many writes as slots get through
        fork
            begin
                for (int i = 0; i < N_PHASE1; i++) write_txn();
            end
            begin
                wait (aw_b_cnt == `AXI_MAX_TXNS);
                repeat (20) @(negedge clk_i);
                check_val("mst_req.aw handshakes with B held", aw_b_cnt, `AXI_MAX_TXNS);
                hold_b = 1'b0;
            end
        join

        fork
            begin
                for (int i = 0; i < N_WR; i++) write_txn();
            end
            begin
                for (int i = 0; i < N_RD; i++) read_txn();
            end
        join

        wait (b_a_cnt == N_PHASE1 + N_WR && rlast_a_cnt == N_RD);
        repeat (4) @(posedge clk_i);
        #1 check_end = 1'b1;
        @(posedge clk_i);
        #1 check_end = 1'b0;
        @(posedge clk_i);
        $display("scoreboard errors %0d, ID check errors %0d", sb_errors, errors);
        if (sb_errors == 0 && errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+logic
logic/axi_pkg.sv
logic/remap_pkg.sv
logic/axi_chan_reg.sv
logic/axi_id_table.sv
logic/axi_id_remap.sv
sim/axi_channel_compare.sv
sim/tb_axi_id_remap.sv

// File: Makefile
# Verilator flow for the AXI ID remapper testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_id_remap
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -F '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(BUILD_DIR)
